// ==== common/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width, rv32
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// fetch starts here after arstN
`define RESET_PC 32'h0000_0000

// fixed instruction length in bytes
`define INSTR_BYTES 4

`endif

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011, // reg-reg alu
        OP_IMM    = 7'b0010011, // reg-imm alu
        OP_LOAD   = 7'b0000011, // lw only
        OP_STORE  = 7'b0100011, // sw only
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcodeT;

    // branch conditions, funct3 of OP_BRANCH
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100, // signed
        BGE  = 3'b101, // signed
        BLTU = 3'b110,
        BGEU = 3'b111
    } branchFunctT;

    // alu funct3 for OP_R and OP_IMM
    typedef enum logic [2:0] {
        F_ADD  = 3'b000, // add or sub, funct7 decides for r-type
        F_SLL  = 3'b001,
        F_SLT  = 3'b010,
        F_SLTU = 3'b011,
        F_XOR  = 3'b100,
        F_SR   = 3'b101, // srl or sra via funct7 bit 5
        F_OR   = 3'b110,
        F_AND  = 3'b111
    } aluFunctT;

endpackage

// ==== common/rvCtrlPkg.sv ====
package rvCtrlPkg;

    // operation class from main decoder
    typedef enum logic [1:0] {
        AOP_ADD       = 2'b00, // address calc, auipc, lui
        AOP_SUB       = 2'b01, // branch compare
        AOP_FUNCT     = 2'b10, // r-type
        AOP_FUNCT_IMM = 2'b11  // i-type alu
    } aluOpT;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10 // lui
    } aluCtrlT;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10 // link value
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_U = 3'b011,
        IMM_J = 3'b100
    } immSrcT;

    // next pc select
    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_TARGET = 2'b01, // pc + imm
        PC_REG    = 2'b10  // alu result, bit 0 cleared
    } pcSrcT;

endpackage

// ==== decode/ControlUnit.sv ====
`timescale 1ns/1ps

module ControlUnit (
    input  rvIsaPkg::opcodeT    opcode,    // instr[6:0]
    input  logic [2:0]          funct3,
    input  logic                zero,      // flags from a - b
    input  logic                lessThan,
    input  logic                lessThanU,
    output logic                regWrite,
    output logic                aluSrcA,   // 1 selects pc
    output logic                aluSrcB,   // 1 selects immediate
    output rvCtrlPkg::immSrcT   immSrc,
    output rvCtrlPkg::resultSrcT resultSrc,
    output logic                memWrite,
    output rvCtrlPkg::aluOpT    aluOp,
    output rvCtrlPkg::pcSrcT    pcSrc
);

    logic takeBranch; // branch condition holds

    // branch condition on alu flags
    always_comb begin
        case (rvIsaPkg::branchFunctT'(funct3))
            rvIsaPkg::BEQ:  takeBranch = zero;
            rvIsaPkg::BNE:  takeBranch = !zero;
            rvIsaPkg::BLT:  takeBranch = lessThan;
            rvIsaPkg::BGE:  takeBranch = !lessThan;
            rvIsaPkg::BLTU: takeBranch = lessThanU;
            rvIsaPkg::BGEU: takeBranch = !lessThanU;
            default:        takeBranch = 1'b0; // funct3 2,3 never taken
        endcase
    end

    always_comb begin
        // defaults, also what an unknown opcode gets
        regWrite  = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        immSrc    = rvCtrlPkg::IMM_I;
        resultSrc = rvCtrlPkg::RES_ALU;
        memWrite  = 1'b0;
        aluOp     = rvCtrlPkg::AOP_ADD;
        pcSrc     = rvCtrlPkg::PC_PLUS4;

        case (opcode)
            rvIsaPkg::OP_R: begin
                regWrite = 1'b1;
                aluOp    = rvCtrlPkg::AOP_FUNCT;
            end
            rvIsaPkg::OP_IMM: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = rvCtrlPkg::AOP_FUNCT_IMM;
            end
            rvIsaPkg::OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;                  // rs1 + imm
                resultSrc = rvCtrlPkg::RES_MEM;
            end
            rvIsaPkg::OP_STORE: begin
                aluSrcB  = 1'b1;
                immSrc   = rvCtrlPkg::IMM_S;
                memWrite = 1'b1;
            end
            rvIsaPkg::OP_BRANCH: begin
                immSrc = rvCtrlPkg::IMM_B;
                aluOp  = rvCtrlPkg::AOP_SUB;       // rs1 - rs2 for flags
                pcSrc  = takeBranch ? rvCtrlPkg::PC_TARGET : rvCtrlPkg::PC_PLUS4;
            end
            rvIsaPkg::OP_JAL: begin
                regWrite  = 1'b1;
                immSrc    = rvCtrlPkg::IMM_J;
                resultSrc = rvCtrlPkg::RES_PC4;    // link
                pcSrc     = rvCtrlPkg::PC_TARGET;
            end
            rvIsaPkg::OP_JALR: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;                  // target = rs1 + imm
                resultSrc = rvCtrlPkg::RES_PC4;
                pcSrc     = rvCtrlPkg::PC_REG;
            end
            rvIsaPkg::OP_LUI: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = rvCtrlPkg::IMM_U;       // passed through by alu
            end
            rvIsaPkg::OP_AUIPC: begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;                   // pc + upper imm
                aluSrcB  = 1'b1;
                immSrc   = rvCtrlPkg::IMM_U;
            end
            default: ; // unsupported, no writes, pc + 4
        endcase
    end

endmodule

// ==== decode/AluDecoder.sv ====
`timescale 1ns/1ps

module AluDecoder (
    input  rvCtrlPkg::aluOpT   aluOp,
    input  logic [2:0]         funct3,
    input  logic               funct7b5, // instr[30]
    input  logic               isLui,
    output rvCtrlPkg::aluCtrlT aluCtrl
);

    logic isRType; // sub only exists in reg-reg form

    assign isRType = (aluOp == rvCtrlPkg::AOP_FUNCT);

    always_comb begin
        aluCtrl = rvCtrlPkg::ALU_ADD;
        if (isLui) begin
            aluCtrl = rvCtrlPkg::ALU_PASSB; // rd = upper imm
        end else begin
            case (aluOp)
                rvCtrlPkg::AOP_ADD: aluCtrl = rvCtrlPkg::ALU_ADD;
                rvCtrlPkg::AOP_SUB: aluCtrl = rvCtrlPkg::ALU_SUB;
                default: begin
                    // funct3 picks the op for both alu formats
                    case (rvIsaPkg::aluFunctT'(funct3))
                        rvIsaPkg::F_ADD:
                            aluCtrl = (isRType && funct7b5) ? rvCtrlPkg::ALU_SUB
                                                            : rvCtrlPkg::ALU_ADD;
                        rvIsaPkg::F_SLL:  aluCtrl = rvCtrlPkg::ALU_SLL;
                        rvIsaPkg::F_SLT:  aluCtrl = rvCtrlPkg::ALU_SLT;
                        rvIsaPkg::F_SLTU: aluCtrl = rvCtrlPkg::ALU_SLTU;
                        rvIsaPkg::F_XOR:  aluCtrl = rvCtrlPkg::ALU_XOR;
                        rvIsaPkg::F_SR:
                            aluCtrl = funct7b5 ? rvCtrlPkg::ALU_SRA  // srai too
                                               : rvCtrlPkg::ALU_SRL;
                        rvIsaPkg::F_OR:   aluCtrl = rvCtrlPkg::ALU_OR;
                        rvIsaPkg::F_AND:  aluCtrl = rvCtrlPkg::ALU_AND;
                        default:          aluCtrl = rvCtrlPkg::ALU_ADD;
                    endcase
                end
            endcase
        end
    end

endmodule

// ==== decode/ImmExtend.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module ImmExtend (
    input  logic [31:7]        instr,  // opcode bits not needed
    input  rvCtrlPkg::immSrcT  immSrc,
    output logic [`XLEN-1:0]   immExt
);

    always_comb begin
        case (immSrc)
            rvCtrlPkg::IMM_I: // addi, lw, jalr
                immExt = {{20{instr[31]}}, instr[31:20]};
            rvCtrlPkg::IMM_S: // split imm for sw
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvCtrlPkg::IMM_B: // half-word offset, bit 0 implied
                immExt = {{19{instr[31]}}, instr[31], instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            rvCtrlPkg::IMM_U:
                immExt = {instr[31:12], 12'b0};
            rvCtrlPkg::IMM_J: // jal offset, +-1 MiB
                immExt = {{11{instr[31]}}, instr[31], instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            default:
                immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== execute/Alu.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module Alu (
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  rvCtrlPkg::aluCtrlT aluCtrl,
    output logic [`XLEN-1:0]   result,
    output logic               zero,      // a == b
    output logic               lessThan,  // signed a < b
    output logic               lessThanU  // unsigned a < b
);

    logic [`XLEN:0]   diffWide; // extra bit carries the borrow
    logic [`XLEN-1:0] diff;
    logic [4:0]       shamt;

    assign diffWide = {1'b0, a} - {1'b0, b};
    assign diff     = diffWide[`XLEN-1:0];
    assign shamt    = b[4:0]; // only low five bits count

    // flags always from the subtraction, independent of aluCtrl
    assign zero      = (diff == '0);
    assign lessThanU = diffWide[`XLEN];                 // borrow out
    assign lessThan  = (a[`XLEN-1] ^ b[`XLEN-1]) ? a[`XLEN-1]
                                                 : diff[`XLEN-1]; // no overflow when signs match

    always_comb begin
        case (aluCtrl)
            rvCtrlPkg::ALU_ADD:   result = a + b;
            rvCtrlPkg::ALU_SUB:   result = diff;
            rvCtrlPkg::ALU_SLL:   result = a << shamt;
            rvCtrlPkg::ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lessThan};
            rvCtrlPkg::ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, lessThanU};
            rvCtrlPkg::ALU_XOR:   result = a ^ b;
            rvCtrlPkg::ALU_SRL:   result = a >> shamt;
            rvCtrlPkg::ALU_SRA:   result = $signed(a) >>> shamt; // sign fill
            rvCtrlPkg::ALU_OR:    result = a | b;
            rvCtrlPkg::ALU_AND:   result = a & b;
            rvCtrlPkg::ALU_PASSB: result = b;                    // lui
            default:              result = a + b;
        endcase
    end

endmodule

// ==== design/RegFile.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module RegFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic                   we,
    input  logic [`XLEN-1:0]       wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    // async read, new value visible after the edge
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// ==== design/PcWriteback.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module PcWriteback (
    input  logic                  clk,
    input  logic                  arstN,
    input  rvCtrlPkg::pcSrcT      pcSrc,
    input  logic [`XLEN-1:0]      immExt,
    input  logic [`XLEN-1:0]      aluResult,
    input  logic [`XLEN-1:0]      dataRdata,  // load data, combinational
    input  rvCtrlPkg::resultSrcT  resultSrc,
    output logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      result      // to regfile wd
);

    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget; // branch and jal target
    logic [`XLEN-1:0] pcNext;

    assign pcPlus4  = pc + `XLEN'(`INSTR_BYTES);
    assign pcTarget = pc + immExt;

    always_comb begin
        case (pcSrc)
            rvCtrlPkg::PC_PLUS4:  pcNext = pcPlus4;
            rvCtrlPkg::PC_TARGET: pcNext = pcTarget;
            rvCtrlPkg::PC_REG:    pcNext = {aluResult[`XLEN-1:1], 1'b0}; // jalr
            default:              pcNext = pcPlus4;
        endcase
    end

    // updates on the same edge as the regfile write
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // writeback mux
    always_comb begin
        case (resultSrc)
            rvCtrlPkg::RES_ALU: result = aluResult;
            rvCtrlPkg::RES_MEM: result = dataRdata;
            rvCtrlPkg::RES_PC4: result = pcPlus4;  // link for jal, jalr
            default:            result = aluResult;
        endcase
    end

endmodule

// ==== design/RiscvCore.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module RiscvCore (
    input  logic             clk,
    input  logic             arstN,
    output logic [`XLEN-1:0] pc,
    input  logic [31:0]      instr,     // word at pc
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWdata,
    output logic             dataWe,
    input  logic [`XLEN-1:0] dataRdata  // word at dataAddr
);

    rvIsaPkg::opcodeT     opcode;
    rvCtrlPkg::aluOpT     aluOp;
    rvCtrlPkg::aluCtrlT   aluCtrl;
    rvCtrlPkg::immSrcT    immSrc;
    rvCtrlPkg::resultSrcT resultSrc;
    rvCtrlPkg::pcSrcT     pcSrc;
    logic                 regWrite;
    logic                 aluSrcA;
    logic                 aluSrcB;
    logic                 memWrite;
    logic                 isLui;
    logic                 zero;
    logic                 lessThan;
    logic                 lessThanU;
    logic [`XLEN-1:0]     immExt;
    logic [`XLEN-1:0]     rd1;
    logic [`XLEN-1:0]     rd2;
    logic [`XLEN-1:0]     srcA;
    logic [`XLEN-1:0]     srcB;
    logic [`XLEN-1:0]     aluResult;
    logic [`XLEN-1:0]     wbResult;

    assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
    assign isLui  = (opcode == rvIsaPkg::OP_LUI);

    // operand selects
    assign srcA = aluSrcA ? pc : rd1;     // pc for auipc
    assign srcB = aluSrcB ? immExt : rd2;

    // data port, address always from the alu
    assign dataAddr  = aluResult;
    assign dataWdata = rd2;
    assign dataWe    = memWrite;

    ControlUnit controlUnit_i (
        .opcode   (opcode),
        .funct3   (instr[14:12]),
        .zero     (zero),
        .lessThan (lessThan),
        .lessThanU(lessThanU),
        .regWrite (regWrite),
        .aluSrcA  (aluSrcA),
        .aluSrcB  (aluSrcB),
        .immSrc   (immSrc),
        .resultSrc(resultSrc),
        .memWrite (memWrite),
        .aluOp    (aluOp),
        .pcSrc    (pcSrc)
    );

    AluDecoder aluDecoder_i (
        .aluOp   (aluOp),
        .funct3  (instr[14:12]),
        .funct7b5(instr[30]),
        .isLui   (isLui),
        .aluCtrl (aluCtrl)
    );

    ImmExtend immExtend_i (
        .instr (instr[31:7]),
        .immSrc(immSrc),
        .immExt(immExt)
    );

    Alu alu_i (
        .a        (srcA),
        .b        (srcB),
        .aluCtrl  (aluCtrl),
        .result   (aluResult),
        .zero     (zero),
        .lessThan (lessThan),
        .lessThanU(lessThanU)
    );

    RegFile regFile_i (
        .clk  (clk),
        .arstN(arstN),
        .rs1  (instr[19:15]),
        .rs2  (instr[24:20]),
        .rd   (instr[11:7]),
        .we   (regWrite),
        .wd   (wbResult),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    PcWriteback pcWriteback_i (
        .clk      (clk),
        .arstN    (arstN),
        .pcSrc    (pcSrc),
        .immExt   (immExt),
        .aluResult(aluResult),
        .dataRdata(dataRdata),
        .resultSrc(resultSrc),
        .pc       (pc),
        .result   (wbResult)
    );

endmodule

// ==== verif/RiscvCore_props.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module RiscvCoreProps (
    input logic             clk,
    input logic             arstN,
    input logic [`XLEN-1:0] pc,
    input logic [31:0]      instr,
    input logic             dataWe
);

    // fetch address on a word boundary
    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // only sw drives the write strobe
    weOnlyOnStore: assert property (@(posedge clk) disable iff (!arstN)
        dataWe |-> (instr[6:0] == rvIsaPkg::OP_STORE))
        else $error("dataWe high with opcode %b", instr[6:0]);

    pcKnown: assert property (@(posedge clk)
        arstN |-> !$isunknown(pc))
        else $error("pc unknown out of reset");

endmodule

bind RiscvCore RiscvCoreProps props_i (
    .clk   (clk),
    .arstN (arstN),
    .pc    (pc),
    .instr (instr),
    .dataWe(dataWe)
);

// ==== verif/RiscvCore_tb.sv ====
`timescale 1ns/1ps

`include "rv_defines.svh"

module RiscvCore_tb;

    localparam int NUM_INSTR   = 2000;
    localparam int RUN_LIMIT   = 2100;          // cycles allowed for the run
    localparam int RESET_LIMIT = 20;            // ns allowed for reset release

    logic             clk;
    logic             arstN;
    logic [31:0]      instr;
    logic [`XLEN-1:0] dataRdata;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] dataWdata;
    logic             dataWe;

    logic [31:0]      lfsrState;
    logic [`XLEN-1:0] modelRegs [`NUM_REGS];    // architectural state of the model
    logic [`XLEN-1:0] modelPc;
    logic             expWe;
    logic             expAddrValid;             // load or store this cycle
    logic [`XLEN-1:0] expAddr;
    logic [`XLEN-1:0] expWdata;
    logic             resetOk;
    int               errorCount;
    int               checkCount;

    RiscvCore RiscvCore_i (
        .clk      (clk),
        .arstN    (arstN),
        .pc       (pc),
        .instr    (instr),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataWe   (dataWe),
        .dataRdata(dataRdata)
    );

    always #2 clk = ~clk;                       // 4 ns period

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            val = {val[30:0], lfsrState[0]};
        end
        return val;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    // alt selects sub for funct3 0 and sra for funct3 5
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (rvIsaPkg::aluFunctT'(f3))
            rvIsaPkg::F_ADD:  return alt ? a - b : a + b;
            rvIsaPkg::F_SLL:  return a << b[4:0];
            rvIsaPkg::F_SLT:  return {31'b0, $signed(a) < $signed(b)};
            rvIsaPkg::F_SLTU: return {31'b0, a < b};
            rvIsaPkg::F_XOR:  return a ^ b;
            rvIsaPkg::F_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            rvIsaPkg::F_OR:   return a | b;
            default:          return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (rvIsaPkg::branchFunctT'(f3))
            rvIsaPkg::BEQ:  return a == b;
            rvIsaPkg::BNE:  return a != b;
            rvIsaPkg::BLT:  return $signed(a) < $signed(b);
            rvIsaPkg::BGE:  return $signed(a) >= $signed(b);
            rvIsaPkg::BLTU: return a < b;
            rvIsaPkg::BGEU: return a >= b;
            default:        return 1'b0;
        endcase
    endfunction

    // random fields first, then patched into a legal word per class
    task automatic buildInstruction(output logic [31:0] word);
        logic [31:0] sel;
        logic [31:0] raw;
        sel  = randBits(5);
        raw  = randBits(32);
        word = raw;
        if (sel == 0) begin
            word[6:0] = raw[7] ? 7'b0001111 : 7'b1110011;   // fence or system, unsupported
        end else if (sel < 8) begin
            word[6:0]   = rvIsaPkg::OP_R;
            word[31:25] = (word[14:12] == rvIsaPkg::F_ADD || word[14:12] == rvIsaPkg::F_SR)
                          ? {1'b0, raw[30], 5'b0} : 7'b0;
        end else if (sel < 14) begin
            word[6:0] = rvIsaPkg::OP_IMM;
            if (word[14:12] == rvIsaPkg::F_SLL) word[31:25] = 7'b0;
            if (word[14:12] == rvIsaPkg::F_SR)  word[31:25] = {1'b0, raw[30], 5'b0};
        end else if (sel < 16) begin
            word[6:0]   = rvIsaPkg::OP_LOAD;
            word[14:12] = 3'b010;                          // lw
        end else if (sel < 22) begin
            word[6:0]   = rvIsaPkg::OP_STORE;
            word[14:12] = 3'b010;                          // sw
        end else if (sel < 26) begin
            word[6:0] = rvIsaPkg::OP_BRANCH;
            if (word[14:13] == 2'b01) word[14] = 1'b1;     // funct3 2,3 mapped to bltu/bgeu
            word[8] = 1'b0;                                // imm[1], word offset
        end else if (sel == 26) begin
            word[6:0] = rvIsaPkg::OP_JAL;
            word[21]  = 1'b0;                              // imm[1]
        end else if (sel == 27) begin
            word[6:0]   = rvIsaPkg::OP_JALR;
            word[14:12] = 3'b000;
            word[21:20] = 2'b00;
            if (modelRegs[word[19:15]][1:0] != 2'b00) word[19:15] = 5'd0; // fall back to x0
        end else if (sel < 30) begin
            word[6:0] = rvIsaPkg::OP_LUI;
        end else begin
            word[6:0] = rvIsaPkg::OP_AUIPC;
        end
    endtask

    // reference execution, sets the expected port values before committing
    task automatic modelStep(input logic [31:0] word, input logic [31:0] rdata);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        a      = modelRegs[word[19:15]];
        b      = modelRegs[word[24:20]];
        immI   = {{20{word[31]}}, word[31:20]};
        immS   = {{20{word[31]}}, word[31:25], word[11:7]};
        immB   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        immU   = {word[31:12], 12'b0};
        immJ   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        nextPc = modelPc + 32'd4;
        wr     = 1'b0;
        res    = '0;
        expWe  = 1'b0;
        expAddrValid = 1'b0;
        expAddr  = '0;
        expWdata = '0;
        case (rvIsaPkg::opcodeT'(word[6:0]))
            rvIsaPkg::OP_R: begin
                wr  = 1'b1;
                res = aluRef(word[14:12], word[30], a, b);
            end
            rvIsaPkg::OP_IMM: begin
                wr  = 1'b1;                                // no subi, alt only for srai
                res = aluRef(word[14:12], word[30] && (word[14:12] == rvIsaPkg::F_SR), a, immI);
            end
            rvIsaPkg::OP_LOAD: begin
                wr  = 1'b1;
                res = rdata;
                expAddrValid = 1'b1;
                expAddr      = a + immI;
            end
            rvIsaPkg::OP_STORE: begin
                expWe        = 1'b1;
                expAddrValid = 1'b1;
                expAddr      = a + immS;
                expWdata     = b;
            end
            rvIsaPkg::OP_BRANCH: begin
                if (branchTaken(word[14:12], a, b)) nextPc = modelPc + immB;
            end
            rvIsaPkg::OP_JAL: begin
                wr     = 1'b1;
                res    = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            rvIsaPkg::OP_JALR: begin
                wr     = 1'b1;
                res    = modelPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            rvIsaPkg::OP_LUI: begin
                wr  = 1'b1;
                res = immU;
            end
            rvIsaPkg::OP_AUIPC: begin
                wr  = 1'b1;
                res = modelPc + immU;
            end
            default: ;                                     // unsupported, state unchanged
        endcase
        if (wr && (word[11:7] != 5'd0)) modelRegs[word[11:7]] = res;
        modelPc = nextPc;
    endtask

    task automatic waitForReset(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && (n < RESET_LIMIT)) begin
            if ((arstN === 1'b1) && (pc === `RESET_PC)) begin
                ok = 1'b1;
            end else begin
                #1;
                n++;
            end
        end
        if (!ok) begin
            errorCount++;
            $display("timeout: core did not come out of reset at the reset pc");
        end
    endtask

    task automatic runInstructions();
        int          done;
        int          cycles;
        logic [31:0] word;
        logic [31:0] rdata;
        done   = 0;
        cycles = 0;
        while (done < NUM_INSTR) begin
            if (cycles >= RUN_LIMIT) begin
                errorCount++;
                $display("timeout: instruction run did not finish in %0d cycles", RUN_LIMIT);
                break;
            end
            if (cycles > 0) begin
                @(posedge clk);
                #1;
            end
            buildInstruction(word);
            rdata     = randBits(32);
            instr     = word;
            dataRdata = rdata;
            #2;                                            // outputs settled before next edge
            compareValue("pc", pc, modelPc);
            modelStep(word, rdata);
            compareValue("dataWe", {31'b0, dataWe}, {31'b0, expWe});
            if (expAddrValid) compareValue("dataAddr", dataAddr, expAddr);
            if (expWe) compareValue("dataWdata", dataWdata, expWdata);
            done++;
            cycles++;
        end
    endtask

    initial begin
        lfsrState  = 32'hbb44_c81a;
        errorCount = 0;
        checkCount = 0;
        clk        = 1'b0;
        arstN      = 1'b0;
        instr      = '0;                                   // opcode 0 is unsupported
        dataRdata  = '0;
        modelPc    = `RESET_PC;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        compareValue("pc", pc, `RESET_PC);
        compareValue("dataWe", {31'b0, dataWe}, 32'd0);
        arstN = 1'b1;
        waitForReset(resetOk);
        if (resetOk) runInstructions();
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/rvIsaPkg.sv
common/rvCtrlPkg.sv
decode/ControlUnit.sv
decode/AluDecoder.sv
decode/ImmExtend.sv
execute/Alu.sv
design/RegFile.sv
design/PcWriteback.sv
design/RiscvCore.sv
verif/RiscvCore_props.sv
verif/RiscvCore_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RiscvCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module RiscvCore_tb \
    --Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
